// ==== common/csr_params.svh ====
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Counter and timer addresses
`define CSR_CYCLE     12'hC00
`define CSR_TIME      12'hC01
`define CSR_INSTRET   12'hC02
`define CSR_CYCLEH    12'hC80
`define CSR_TIMEH     12'hC81
`define CSR_INSTRETH  12'hC82

// Machine identity
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID   12'hF12
`define CSR_MIMPID    12'hF13
`define CSR_MHARTID   12'hF14
`define CSR_MISA      12'h301

// Trap registers
`define CSR_MSTATUS   12'h300
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344

// Exception cause codes
`define CAUSE_INSTR_MISALIGNED 5'd0
`define CAUSE_INSTR_ACCESS     5'd1
`define CAUSE_ILLEGAL_INSTR    5'd2
`define CAUSE_BREAKPOINT       5'd3
`define CAUSE_LOAD_MISALIGNED  5'd4
`define CAUSE_LOAD_ACCESS      5'd5
`define CAUSE_STORE_MISALIGNED 5'd6
`define CAUSE_STORE_ACCESS     5'd7
`define CAUSE_ECALL_M          5'd11

// Bit positions in mstatus and mie/mip
`define MSTATUS_MIE    3
`define MSTATUS_MPIE   7
`define MIE_MSIE       3
`define MIE_MTIE       7
`define MIE_MEIE       11
`define USER_IRQ_BASE  16

`endif

// ==== common/csrPkg.sv ====
`default_nettype none

`include "csr_params.svh"

package csrPkg;

	// Pipeline request, write lands on the next edge
	typedef struct packed {
		logic readEnable;
		logic writeEnable;
		logic [11:0] readAddress;
		logic [11:0] writeAddress;
		logic [31:0] writeData;
	} csrReqT;

	// Registered answer of one bank
	typedef struct packed {
		logic hit;
		logic [31:0] data;
	} csrRespT;

	typedef struct packed {
		logic [7:0] coreIndex;
		logic [10:0] manufacturerId;
		logic [15:0] partId;
		logic [3:0] versionId;
		logic [25:0] extensions;
	} sysIdT;

	typedef struct packed {
		logic fetchAddressMisaligned;
		logic jumpMisaligned;
		logic fetchAccessFault;
		logic fetchAddressBreakpoint;
		logic invalidInstruction;
		logic ecall;
		logic ebreak;
		logic loadAddressMisaligned;
		logic storeAddressMisaligned;
		logic loadAccessFault;
		logic storeAccessFault;
		logic dataAddressBreakpoint;
		logic machineTimer;
		logic machineExternal;
		logic machineSoftware;
		logic [15:0] userInterrupts;
	} trapEventsT;

	typedef struct packed {
		logic [31:0] programCounter;
		logic [31:0] currentInstruction;
		logic [31:0] instructionAddress;
		logic [31:0] dataAddress;
	} trapCtxT;

	typedef enum logic [4:0] {
		causeInstrMisaligned = `CAUSE_INSTR_MISALIGNED,
		causeInstrAccess = `CAUSE_INSTR_ACCESS,
		causeIllegalInstr = `CAUSE_ILLEGAL_INSTR,
		causeBreakpoint = `CAUSE_BREAKPOINT,
		causeLoadMisaligned = `CAUSE_LOAD_MISALIGNED,
		causeLoadAccess = `CAUSE_LOAD_ACCESS,
		causeStoreMisaligned = `CAUSE_STORE_MISALIGNED,
		causeStoreAccess = `CAUSE_STORE_ACCESS,
		causeEcallM = `CAUSE_ECALL_M
	} causeT;

endpackage

`default_nettype wire

// ==== rtl/csrCounter.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "csr_params.svh"

module csrCounter #(
	parameter logic [11:0] lowerAddress = `CSR_CYCLE,
	parameter logic [11:0] upperAddress = `CSR_CYCLEH
) (
	input wire clk,
	input wire rstN,
	input wire csrPkg::csrReqT csrReq,
	input wire count,
	output logic [63:0] value,
	output csrPkg::csrRespT resp
);

	logic lowerSel;
	logic upperSel;

	assign lowerSel = csrReq.readAddress == lowerAddress;
	assign upperSel = csrReq.readAddress == upperAddress;

	always_ff @(posedge clk) begin
		// Read returns the count from before this edge
		resp.data <= upperSel ? value[63:32] : value[31:0];
		if (!rstN) begin
			value <= 64'b0;
			resp.hit <= 1'b0;
		end else begin
			if (count)
				value <= value + 64'd1;
			resp.hit <= csrReq.readEnable && (lowerSel || upperSel);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/csrInfoBank.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "csr_params.svh"

module csrInfoBank (
	input wire clk,
	input wire rstN,
	input wire csrPkg::csrReqT csrReq,
	input wire csrPkg::sysIdT sysId,
	input wire [63:0] cycleValue,
	output csrPkg::csrRespT resp
);

	logic readHit;
	logic [31:0] readWord;

	always_comb begin
		readHit = 1'b1;
		case (csrReq.readAddress)
			`CSR_MVENDORID: readWord = {21'b0, sysId.manufacturerId};
			`CSR_MARCHID: readWord = {16'b0, sysId.partId};
			`CSR_MIMPID: readWord = {28'b0, sysId.versionId};
			`CSR_MHARTID: readWord = {24'b0, sysId.coreIndex};
			// MXL of 1 selects RV32
			`CSR_MISA: readWord = {2'b01, 4'b0, sysId.extensions};
			// Time mirrors cycle
			`CSR_TIME: readWord = cycleValue[31:0];
			`CSR_TIMEH: readWord = cycleValue[63:32];
			default: begin
				readHit = 1'b0;
				readWord = 32'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		resp.data <= readWord;
		if (!rstN)
			resp.hit <= 1'b0;
		else
			resp.hit <= csrReq.readEnable && readHit;
	end

endmodule

`default_nettype wire

// ==== traps/trapPriority.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "csr_params.svh"

module trapPriority (
	input wire csrPkg::trapEventsT trapEvents,
	input wire csrPkg::trapCtxT trapCtx,
	input wire [31:0] mie,
	output logic take,
	output logic isInterrupt,
	output csrPkg::causeT cause,
	output logic [31:0] tval
);

	logic [15:0] userPending;
	logic [3:0] userIndex;

	assign userPending = trapEvents.userInterrupts & mie[`USER_IRQ_BASE +: 16];

	// Lowest pending user line wins
	always_comb begin
		userIndex = 4'd0;
		for (int i = 15; i >= 0; i--) begin
			if (userPending[i])
				userIndex = 4'(i);
		end
	end

	// Interrupt cause codes equal their mip bit
	always_comb begin
		take = 1'b1;
		isInterrupt = 1'b0;
		cause = csrPkg::causeBreakpoint;
		tval = 32'b0;
		if (trapEvents.fetchAddressBreakpoint) begin
			cause = csrPkg::causeBreakpoint;
		end else if (trapEvents.fetchAccessFault) begin
			cause = csrPkg::causeInstrAccess;
			tval = trapCtx.instructionAddress;
		end else if (trapEvents.fetchAddressMisaligned || trapEvents.jumpMisaligned) begin
			cause = csrPkg::causeInstrMisaligned;
			tval = trapCtx.instructionAddress;
		end else if (trapEvents.invalidInstruction) begin
			cause = csrPkg::causeIllegalInstr;
			tval = trapCtx.currentInstruction;
		end else if (trapEvents.ecall) begin
			cause = csrPkg::causeEcallM;
		end else if (trapEvents.ebreak) begin
			cause = csrPkg::causeBreakpoint;
		end else if (trapEvents.loadAddressMisaligned) begin
			cause = csrPkg::causeLoadMisaligned;
			tval = trapCtx.dataAddress;
		end else if (trapEvents.storeAddressMisaligned) begin
			cause = csrPkg::causeStoreMisaligned;
			tval = trapCtx.dataAddress;
		end else if (trapEvents.loadAccessFault) begin
			cause = csrPkg::causeLoadAccess;
			tval = trapCtx.dataAddress;
		end else if (trapEvents.storeAccessFault) begin
			cause = csrPkg::causeStoreAccess;
			tval = trapCtx.dataAddress;
		end else if (trapEvents.dataAddressBreakpoint) begin
			cause = csrPkg::causeBreakpoint;
			tval = trapCtx.dataAddress;
		end else if (trapEvents.machineExternal && mie[`MIE_MEIE]) begin
			isInterrupt = 1'b1;
			cause = csrPkg::causeT'(5'(`MIE_MEIE));
		end else if (trapEvents.machineSoftware && mie[`MIE_MSIE]) begin
			isInterrupt = 1'b1;
			cause = csrPkg::causeT'(5'(`MIE_MSIE));
		end else if (trapEvents.machineTimer && mie[`MIE_MTIE]) begin
			isInterrupt = 1'b1;
			cause = csrPkg::causeT'(5'(`MIE_MTIE));
		end else if (|userPending) begin
			isInterrupt = 1'b1;
			cause = csrPkg::causeT'(5'(`USER_IRQ_BASE) + {1'b0, userIndex});
		end else begin
			take = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== traps/csrTraps.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "csr_params.svh"

module csrTraps (
	input wire clk,
	input wire rstN,
	input wire csrPkg::csrReqT csrReq,
	input wire csrPkg::trapEventsT trapEvents,
	input wire csrPkg::trapCtxT trapCtx,
	input wire trapReturn,
	output csrPkg::csrRespT resp,
	output logic inTrap,
	output logic [31:0] trapVector,
	output logic [31:0] trapReturnVector
);

	logic mstatusMie;
	logic mstatusMpie;
	logic [31:0] mie;
	logic [31:0] mtvec;
	logic [31:0] mscratch;
	logic [31:0] mepc;
	logic [31:0] mcause;
	logic [31:0] mtval;
	logic [31:0] mstatus;
	logic [31:0] mip;

	logic take;
	logic isInterrupt;
	csrPkg::causeT cause;
	logic [31:0] tval;
	logic takeTrap;

	logic readHit;
	logic [31:0] readWord;
	logic [31:0] vectorBase;

	trapPriority priorityEncoder (
		.trapEvents(trapEvents),
		.trapCtx(trapCtx),
		.mie(mie),
		.take(take),
		.isInterrupt(isInterrupt),
		.cause(cause),
		.tval(tval));

	// Interrupts also need the global enable
	assign takeTrap = take && !inTrap && (!isInterrupt || mstatusMie);

	always_comb begin
		mstatus = 32'b0;
		mstatus[`MSTATUS_MIE] = mstatusMie;
		mstatus[`MSTATUS_MPIE] = mstatusMpie;
		mip = 32'b0;
		mip[`MIE_MSIE] = trapEvents.machineSoftware;
		mip[`MIE_MTIE] = trapEvents.machineTimer;
		mip[`MIE_MEIE] = trapEvents.machineExternal;
		mip[`USER_IRQ_BASE +: 16] = trapEvents.userInterrupts;
	end

	always_comb begin
		readHit = 1'b1;
		case (csrReq.readAddress)
			`CSR_MSTATUS: readWord = mstatus;
			`CSR_MIE: readWord = mie;
			`CSR_MTVEC: readWord = mtvec;
			`CSR_MSCRATCH: readWord = mscratch;
			`CSR_MEPC: readWord = mepc;
			`CSR_MCAUSE: readWord = mcause;
			`CSR_MTVAL: readWord = mtval;
			`CSR_MIP: readWord = mip;
			default: begin
				readHit = 1'b0;
				readWord = 32'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		resp.data <= readWord;
		if (!rstN) begin
			resp.hit <= 1'b0;
			inTrap <= 1'b0;
			mstatusMie <= 1'b0;
			mstatusMpie <= 1'b0;
			mie <= 32'b0;
			mtvec <= 32'b0;
			mscratch <= 32'b0;
			mepc <= 32'b0;
			mcause <= 32'b0;
			mtval <= 32'b0;
		end else begin
			resp.hit <= csrReq.readEnable && readHit;
			if (csrReq.writeEnable) begin
				case (csrReq.writeAddress)
					`CSR_MSTATUS: begin
						mstatusMie <= csrReq.writeData[`MSTATUS_MIE];
						mstatusMpie <= csrReq.writeData[`MSTATUS_MPIE];
					end
					`CSR_MIE: mie <= csrReq.writeData;
					`CSR_MTVEC: mtvec <= csrReq.writeData;
					`CSR_MSCRATCH: mscratch <= csrReq.writeData;
					`CSR_MEPC: mepc <= csrReq.writeData;
					`CSR_MCAUSE: mcause <= csrReq.writeData;
					`CSR_MTVAL: mtval <= csrReq.writeData;
					default: ;
				endcase
			end
			// Later assignments override a software write
			if (trapReturn && inTrap) begin
				inTrap <= 1'b0;
				mstatusMie <= mstatusMpie;
				mstatusMpie <= 1'b1;
			end
			if (takeTrap) begin
				inTrap <= 1'b1;
				mepc <= trapCtx.programCounter;
				mcause <= {isInterrupt, 26'b0, cause};
				mtval <= tval;
				mstatusMpie <= mstatusMie;
				mstatusMie <= 1'b0;
			end
		end
	end

	assign vectorBase = {mtvec[31:2], 2'b00};

	// Vectored mode only for interrupts
	always_comb begin
		if (mtvec[1:0] == 2'b01 && mcause[31])
			trapVector = vectorBase + {25'b0, mcause[4:0], 2'b00};
		else
			trapVector = vectorBase;
	end

	assign trapReturnVector = mepc;

endmodule

`default_nettype wire

// ==== rtl/csrFile.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "csr_params.svh"

module csrFile (
	input wire clk,
	input wire rstN,

	input wire csrPkg::csrReqT csrReq,
	output logic [31:0] csrReadData,

	input wire csrPkg::sysIdT sysId,
	input wire instructionCompleted,

	input wire csrPkg::trapEventsT trapEvents,
	input wire csrPkg::trapCtxT trapCtx,
	input wire trapReturn,
	output logic inTrap,
	output logic [31:0] trapVector,
	output logic [31:0] trapReturnVector
);

	logic [63:0] cycleValue;
	csrPkg::csrRespT cycleResp;
	csrPkg::csrRespT instretResp;
	csrPkg::csrRespT infoResp;
	csrPkg::csrRespT trapResp;

	csrCounter #(.lowerAddress(`CSR_CYCLE), .upperAddress(`CSR_CYCLEH)) cycleCounter (
		.clk(clk),
		.rstN(rstN),
		.csrReq(csrReq),
		.count(1'b1),
		.value(cycleValue),
		.resp(cycleResp));

	// Full instret value has no other reader
	csrCounter #(.lowerAddress(`CSR_INSTRET), .upperAddress(`CSR_INSTRETH)) instretCounter (
		.clk(clk),
		.rstN(rstN),
		.csrReq(csrReq),
		.count(instructionCompleted),
		.value(),
		.resp(instretResp));

	csrInfoBank infoBank (
		.clk(clk),
		.rstN(rstN),
		.csrReq(csrReq),
		.sysId(sysId),
		.cycleValue(cycleValue),
		.resp(infoResp));

	csrTraps traps (
		.clk(clk),
		.rstN(rstN),
		.csrReq(csrReq),
		.trapEvents(trapEvents),
		.trapCtx(trapCtx),
		.trapReturn(trapReturn),
		.resp(trapResp),
		.inTrap(inTrap),
		.trapVector(trapVector),
		.trapReturnVector(trapReturnVector));

	// Decode guarantees at most one hit
	always_comb begin
		csrReadData = (cycleResp.hit ? cycleResp.data : 32'b0)
			| (instretResp.hit ? instretResp.data : 32'b0)
			| (infoResp.hit ? infoResp.data : 32'b0)
			| (trapResp.hit ? trapResp.data : 32'b0);
	end

endmodule

`default_nettype wire

// ==== test/csrFile_asserts.sv ====
`default_nettype none
`timescale 1ns/1ps

module csrFileAsserts (
	input wire clk,
	input wire rstN,
	input wire csrPkg::trapEventsT trapEvents,
	input wire trapReturn,
	input wire inTrap
);

	logic anyException;

	assign anyException = trapEvents.fetchAddressMisaligned | trapEvents.jumpMisaligned
		| trapEvents.fetchAccessFault | trapEvents.fetchAddressBreakpoint
		| trapEvents.invalidInstruction | trapEvents.ecall | trapEvents.ebreak
		| trapEvents.loadAddressMisaligned | trapEvents.storeAddressMisaligned
		| trapEvents.loadAccessFault | trapEvents.storeAccessFault
		| trapEvents.dataAddressBreakpoint;

	resetLeavesNoTrap: assert property (@(posedge clk) !rstN |=> !inTrap)
		else $error("inTrap is not low on the cycle after reset");

	// Exceptions need no enable
	exceptionEntersTrap: assert property (@(posedge clk) disable iff (!rstN)
		(anyException && !inTrap) |=> inTrap)
		else $error("Exception while idle did not raise inTrap");

	returnLeavesTrap: assert property (@(posedge clk) disable iff (!rstN)
		(trapReturn && inTrap) |=> !inTrap)
		else $error("trapReturn did not clear inTrap");

endmodule

bind csrFile csrFileAsserts asserts (
	.clk(clk),
	.rstN(rstN),
	.trapEvents(trapEvents),
	.trapReturn(trapReturn),
	.inTrap(inTrap));

`default_nettype wire

// ==== test/csrFileTb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "csr_params.svh"

module csrFileTb;

	localparam int clockPeriod = 20;
	localparam int resetCycles = 5;
	// Worst case per test, random waits included
	localparam int identityCycles = 12;
	localparam int counterCycles = 24;
	localparam int instretCycles = 24;
	localparam int registerCycles = 16;
	localparam int exceptionCycles = 16;
	localparam int interruptCycles = 14;
	localparam int timeoutCycles = 2 * (resetCycles + identityCycles + counterCycles
		+ instretCycles + registerCycles + exceptionCycles + interruptCycles);

	logic clk = 1'b0;
	logic rstN;
	csrPkg::csrReqT csrReq;
	logic [31:0] csrReadData;
	csrPkg::sysIdT sysId;
	logic instructionCompleted;
	csrPkg::trapEventsT trapEvents;
	csrPkg::trapCtxT trapCtx;
	logic trapReturn;
	logic inTrap;
	logic [31:0] trapVector;
	logic [31:0] trapReturnVector;
	int unsigned seed;

	csrFile dut (
		.clk(clk),
		.rstN(rstN),
		.csrReq(csrReq),
		.csrReadData(csrReadData),
		.sysId(sysId),
		.instructionCompleted(instructionCompleted),
		.trapEvents(trapEvents),
		.trapCtx(trapCtx),
		.trapReturn(trapReturn),
		.inTrap(inTrap),
		.trapVector(trapVector),
		.trapReturnVector(trapReturnVector));

	initial begin
		forever #(clockPeriod / 2) clk = ~clk;
	end

	initial begin
		repeat (timeoutCycles) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", timeoutCycles);
		abortRun();
	end

	task automatic abortRun();
		$display("sim failed");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("[ERROR] %s: expected %h, actual %h", testName, expected, actual);
			abortRun();
		end
	endtask

	// Answer arrives one cycle after the strobe
	task automatic readCsr(input logic [11:0] address, output logic [31:0] data);
		csrReq.readEnable = 1'b1;
		csrReq.readAddress = address;
		@(negedge clk);
		data = csrReadData;
		csrReq.readEnable = 1'b0;
	endtask

	task automatic expectCsr(input string testName, input logic [11:0] address,
		input logic [31:0] expected);
		logic [31:0] data;
		readCsr(address, data);
		checkValue(testName, expected, data);
	endtask

	task automatic writeCsr(input logic [11:0] address, input logic [31:0] data);
		csrReq.writeEnable = 1'b1;
		csrReq.writeAddress = address;
		csrReq.writeData = data;
		@(negedge clk);
		csrReq.writeEnable = 1'b0;
	endtask

	task automatic writeReadBack(input string testName, input logic [11:0] address);
		logic [31:0] value;
		value = $urandom;
		writeCsr(address, value);
		expectCsr(testName, address, value);
	endtask

	// Events held for exactly one edge
	task automatic pulseEvents(input csrPkg::trapEventsT events);
		trapEvents = events;
		@(negedge clk);
		trapEvents = '0;
	endtask

	task automatic returnFromTrap(input string testName);
		trapReturn = 1'b1;
		@(negedge clk);
		trapReturn = 1'b0;
		checkValue(testName, 32'd0, {31'b0, inTrap});
	endtask

	task automatic testIdentity();
		sysId.coreIndex = 8'($urandom);
		sysId.manufacturerId = 11'($urandom);
		sysId.partId = 16'($urandom);
		sysId.versionId = 4'($urandom);
		sysId.extensions = 26'($urandom);
		expectCsr("identity mvendorid", `CSR_MVENDORID, {21'b0, sysId.manufacturerId});
		expectCsr("identity marchid", `CSR_MARCHID, {16'b0, sysId.partId});
		expectCsr("identity mimpid", `CSR_MIMPID, {28'b0, sysId.versionId});
		expectCsr("identity mhartid", `CSR_MHARTID, {24'b0, sysId.coreIndex});
		expectCsr("identity misa", `CSR_MISA, {2'b01, 4'b0, sysId.extensions});
		expectCsr("identity unmapped", 12'h7C0, 32'b0);
		writeCsr(`CSR_MHARTID, $urandom);
		expectCsr("identity write ignored", `CSR_MHARTID, {24'b0, sysId.coreIndex});
	endtask

	task automatic testCounters();
		int gap;
		logic [31:0] cycleA;
		logic [31:0] cycleB;
		logic [31:0] timeLow;
		gap = 2 + int'($urandom % 15);
		readCsr(`CSR_CYCLE, cycleA);
		repeat (gap - 1) @(negedge clk);
		readCsr(`CSR_CYCLE, cycleB);
		checkValue("cycle gap", cycleA + 32'(gap), cycleB);
		// Strobed one edge after the second cycle read
		readCsr(`CSR_TIME, timeLow);
		checkValue("time alias", cycleB + 32'd1, timeLow);
		expectCsr("cycleh early", `CSR_CYCLEH, 32'b0);
		expectCsr("timeh early", `CSR_TIMEH, 32'b0);
	endtask

	task automatic testInstret();
		int pulses;
		logic [31:0] countBefore;
		logic [31:0] countAfter;
		pulses = 1 + int'($urandom % 20);
		readCsr(`CSR_INSTRET, countBefore);
		instructionCompleted = 1'b1;
		repeat (pulses) @(negedge clk);
		instructionCompleted = 1'b0;
		readCsr(`CSR_INSTRET, countAfter);
		checkValue("instret pulses", countBefore + 32'(pulses), countAfter);
		expectCsr("instreth early", `CSR_INSTRETH, 32'b0);
	endtask

	task automatic testTrapRegisters();
		writeReadBack("mscratch readback", `CSR_MSCRATCH);
		writeReadBack("mtvec readback", `CSR_MTVEC);
		writeReadBack("mepc readback", `CSR_MEPC);
		writeReadBack("mie readback", `CSR_MIE);
		writeCsr(`CSR_MIE, 32'b0);
		writeCsr(`CSR_MSTATUS, 32'hFFFF_FFFF);
		expectCsr("mstatus mask", `CSR_MSTATUS, 32'h0000_0088);
		writeCsr(`CSR_MSTATUS, 32'h0000_0008);
	endtask

	task automatic testExceptions();
		csrPkg::trapEventsT events;
		trapCtx = {$urandom, $urandom, $urandom, $urandom};
		events = '0;
		events.invalidInstruction = 1'b1;
		pulseEvents(events);
		checkValue("illegal entry", 32'd1, {31'b0, inTrap});
		expectCsr("illegal mcause", `CSR_MCAUSE, 32'd2);
		expectCsr("illegal mtval", `CSR_MTVAL, trapCtx.currentInstruction);
		expectCsr("illegal mepc", `CSR_MEPC, trapCtx.programCounter);
		checkValue("illegal return vector", trapCtx.programCounter, trapReturnVector);
		expectCsr("illegal mstatus", `CSR_MSTATUS, 32'h0000_0080);
		returnFromTrap("illegal return");
		expectCsr("illegal mstatus restored", `CSR_MSTATUS, 32'h0000_0088);
		events = '0;
		events.loadAccessFault = 1'b1;
		events.ecall = 1'b1;
		pulseEvents(events);
		checkValue("ecall entry", 32'd1, {31'b0, inTrap});
		expectCsr("ecall over load fault", `CSR_MCAUSE, 32'd11);
		expectCsr("ecall mtval", `CSR_MTVAL, 32'd0);
		returnFromTrap("ecall return");
	endtask

	task automatic testInterrupts();
		csrPkg::trapEventsT events;
		logic [31:0] base;
		logic [15:0] userLevels;
		base = $urandom & 32'hFFFF_FFFC;
		userLevels = 16'($urandom);
		writeCsr(`CSR_MTVEC, base | 32'd1);
		writeCsr(`CSR_MIE, 32'd1 << `MIE_MTIE);
		writeCsr(`CSR_MSTATUS, 32'h0000_0008);
		trapCtx.programCounter = $urandom;
		events = '0;
		events.machineExternal = 1'b1;
		events.userInterrupts = userLevels;
		trapEvents = events;
		@(negedge clk);
		checkValue("disabled external", 32'd0, {31'b0, inTrap});
		expectCsr("mip levels", `CSR_MIP, {userLevels, 4'b0, 1'b1, 11'b0});
		events.machineTimer = 1'b1;
		pulseEvents(events);
		checkValue("timer entry", 32'd1, {31'b0, inTrap});
		expectCsr("timer mcause", `CSR_MCAUSE, 32'h8000_0007);
		checkValue("timer vector", base + 32'd28, trapVector);
		expectCsr("timer mepc", `CSR_MEPC, trapCtx.programCounter);
		returnFromTrap("timer return");
	endtask

	initial begin
		seed = 32'h088f_0d68;
		void'($urandom(seed));
		rstN = 1'b0;
		csrReq = '0;
		sysId = '0;
		instructionCompleted = 1'b0;
		trapEvents = '0;
		trapCtx = '0;
		trapReturn = 1'b0;
		repeat (resetCycles) @(negedge clk);
		rstN = 1'b1;
		checkValue("reset inTrap", 32'd0, {31'b0, inTrap});
		checkValue("reset read data", 32'd0, csrReadData);
		testIdentity();
		testCounters();
		testInstret();
		testTrapRegisters();
		testExceptions();
		testInterrupts();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== csrFile.f ====
+incdir+common
common/csrPkg.sv
rtl/csrCounter.sv
rtl/csrInfoBank.sv
traps/trapPriority.sv
traps/csrTraps.sv
rtl/csrFile.sv
test/csrFile_asserts.sv
test/csrFileTb.sv
